/* source/video_pkg.sv */
package video_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // raster coordinates
    ////////////////////////////////////////////////////////////////////////////

    // wide enough for 640x480 totals and a bit more
    localparam int CNT_W = 11;

    // one raster coordinate, unsigned
    typedef logic [CNT_W-1:0] cnt_t;

    // beam position plus its decoded flags
    // h_cnt/v_cnt are full-resolution counts
    typedef struct packed {
        cnt_t h_cnt;
        cnt_t v_cnt;
        // inside the visible area
        logic active;
        // syncs are active high
        logic hsync;
        logic vsync;
    } beam_t;

    ////////////////////////////////////////////////////////////////////////////
    // colour and output word
    ////////////////////////////////////////////////////////////////////////////

    // 4 bits per channel
    localparam int CHAN_W = 4;

    typedef logic [CHAN_W-1:0] chan_t;

    // 12-bit colour, red in the top nibble
    typedef struct packed {
        chan_t r;
        chan_t g;
        chan_t b;
    } rgb_t;

    // one video word per clock, 16 bits
    typedef struct packed {
        logic hsync;
        logic vsync;
        // data enable, same as active
        logic de;
        // pixel belongs to a lit glyph bit
        logic text_on;
        rgb_t rgb;
    } video_t;

endpackage

/* source/font_pkg.sv */
package font_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // font geometry
    ////////////////////////////////////////////////////////////////////////////

    // glyph cell in half-resolution pixels
    localparam int FONT_W = 8;
    localparam int FONT_H = 8;

    // number of glyphs held in the rom
    localparam int FONT_GLYPHS = 8;

    // bits for a glyph code and for a row/column inside a cell
    localparam int GLYPH_W    = $clog2(FONT_GLYPHS);
    localparam int FONT_POS_W = $clog2(FONT_H);

    ////////////////////////////////////////////////////////////////////////////
    // glyph types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [GLYPH_W-1:0] glyph_t;

    // row or column index within one cell
    typedef logic [FONT_POS_W-1:0] font_pos_t;

    // rom address is {glyph, row}
    typedef logic [GLYPH_W+FONT_POS_W-1:0] font_addr_t;

    // one bitmap row, bit 7 is the leftmost pixel
    typedef logic [FONT_W-1:0] font_row_t;

    // codes of the glyphs in the rom
    typedef enum glyph_t {
        SPACE = 3'd0,
        A     = 3'd1,
        B     = 3'd2,
        C     = 3'd3,
        D     = 3'd4,
        ZERO  = 3'd5,
        ONE   = 3'd6,
        TWO   = 3'd7
    } glyph_code_e;

endpackage

/* source/video_timing.sv */
module video_timing
    import video_pkg::*;
#(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  logic  clk,
    input  logic  rst_n,
    output beam_t beam
);

    // full line and frame lengths
    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    // last count before wrap
    localparam cnt_t H_LAST = cnt_t'(H_TOTAL - 1);
    localparam cnt_t V_LAST = cnt_t'(V_TOTAL - 1);

    // end of the visible part
    localparam cnt_t H_ACT = cnt_t'(H_ACTIVE);
    localparam cnt_t V_ACT = cnt_t'(V_ACTIVE);

    // sync window, after the front porch
    localparam cnt_t H_SYNC_BEG = cnt_t'(H_ACTIVE + H_FRONT);
    localparam cnt_t H_SYNC_END = cnt_t'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam cnt_t V_SYNC_BEG = cnt_t'(V_ACTIVE + V_FRONT);
    localparam cnt_t V_SYNC_END = cnt_t'(V_ACTIVE + V_FRONT + V_SYNC);

    cnt_t h_cnt;
    cnt_t v_cnt;
    logic h_wrap;
    logic v_wrap;

    assign h_wrap = (h_cnt == H_LAST);
    assign v_wrap = (v_cnt == V_LAST);

    ////////////////////////////////////////////////////////////////////////////
    // counters
    ////////////////////////////////////////////////////////////////////////////

    // v_cnt steps once per line, on the h wrap
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            if (h_wrap) begin
                h_cnt <= '0;
                v_cnt <= v_wrap ? '0 : v_cnt + 1'b1;
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // flag decode
    ////////////////////////////////////////////////////////////////////////////

    // flags follow the counters in the same cycle
    always_comb begin
        beam.h_cnt  = h_cnt;
        beam.v_cnt  = v_cnt;
        beam.active = (h_cnt < H_ACT) && (v_cnt < V_ACT);
        // hsync for H_SYNC clocks
        beam.hsync  = (h_cnt >= H_SYNC_BEG) && (h_cnt < H_SYNC_END);
        // vsync for V_SYNC lines
        beam.vsync  = (v_cnt >= V_SYNC_BEG) && (v_cnt < V_SYNC_END);
    end

endmodule

/* source/text_ctrl.sv */
module text_ctrl
    import video_pkg::*;
    import font_pkg::*;
#(
    parameter int STR_LEN = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  beam_t                beam_in,
    // string origin, half-resolution
    input  cnt_t                 text_h,
    input  cnt_t                 text_v,
    // element 0 is the leftmost glyph
    input  glyph_t [STR_LEN-1:0] text_str,
    output beam_t                beam_out,
    output logic                 in_text,
    output glyph_t               glyph,
    output cnt_t                 cell_h,
    output cnt_t                 cell_v
);

    // glyph index width, at least one bit
    localparam int IDX_W = (STR_LEN > 1) ? $clog2(STR_LEN) : 1;

    // size of the string rectangle, half-resolution
    localparam cnt_t SPAN_H = cnt_t'(FONT_W * STR_LEN);
    localparam cnt_t SPAN_V = cnt_t'(FONT_H);

    cnt_t             half_h;
    cnt_t             half_v;
    cnt_t             off_h;
    cnt_t             off_v;
    logic             hit_h;
    logic             hit_v;
    logic             hit;
    logic [IDX_W-1:0] idx;
    glyph_t           glyph_d;
    cnt_t             cell_h_d;

    ////////////////////////////////////////////////////////////////////////////
    // rectangle test
    ////////////////////////////////////////////////////////////////////////////

    // 2x scaling by halving the beam
    assign half_h = beam_in.h_cnt >> 1;
    assign half_v = beam_in.v_cnt >> 1;

    // offsets into the string, wrap when left/above
    assign off_h = half_h - text_h;
    assign off_v = half_v - text_v;

    // lower bound checked first, so wrapped offsets never hit
    assign hit_h = (half_h >= text_h) && (off_h < SPAN_H);
    assign hit_v = (half_v >= text_v) && (off_v < SPAN_V);
    assign hit   = hit_h && hit_v;

    ////////////////////////////////////////////////////////////////////////////
    // glyph select
    ////////////////////////////////////////////////////////////////////////////

    // which glyph of the string, only meaningful on a hit
    assign idx = IDX_W'(off_h / FONT_W);

    // blank code outside the string
    assign glyph_d = hit ? text_str[idx] : SPACE;

    // left edge of the selected cell
    assign cell_h_d = text_h + cnt_t'(FONT_W * idx);

    // flags and beam, cleared on reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beam_out <= '0;
            in_text  <= 1'b0;
        end else begin
            beam_out <= beam_in;
            in_text  <= hit;
        end
    end

    // payload, qualified by in_text downstream
    always_ff @(posedge clk) begin
        glyph  <= glyph_d;
        cell_h <= cell_h_d;
        // every cell starts on the string's top line
        cell_v <= text_v;
    end

endmodule

/* source/font_rom.sv */
module font_rom
    import font_pkg::*;
(
    input  logic       clk,
    input  font_addr_t addr,
    output font_row_t  row
);

    glyph_code_e             code;
    font_pos_t               cell_row;
    // entry 0 is the top row
    font_row_t [0:FONT_H-1]  bitmap;

    // address split, glyph in the upper bits
    assign code     = glyph_code_e'(addr[FONT_POS_W +: GLYPH_W]);
    assign cell_row = addr[FONT_POS_W-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // bitmaps
    ////////////////////////////////////////////////////////////////////////////

    // rows listed top to bottom, msb is the left pixel
    // bottom row left empty as spacing between lines
    always_comb begin
        case (code)
            SPACE: begin
                bitmap = '0;
            end
            A: begin
                bitmap = {8'h18, 8'h24, 8'h42, 8'h42, 8'h7e, 8'h42, 8'h42, 8'h00};
            end
            B: begin
                bitmap = {8'h7c, 8'h42, 8'h42, 8'h7c, 8'h42, 8'h42, 8'h7c, 8'h00};
            end
            C: begin
                bitmap = {8'h3c, 8'h42, 8'h40, 8'h40, 8'h40, 8'h42, 8'h3c, 8'h00};
            end
            D: begin
                bitmap = {8'h78, 8'h44, 8'h42, 8'h42, 8'h42, 8'h44, 8'h78, 8'h00};
            end
            // zero with a slash, tells it apart from the letter
            ZERO: begin
                bitmap = {8'h3c, 8'h46, 8'h4a, 8'h52, 8'h62, 8'h42, 8'h3c, 8'h00};
            end
            ONE: begin
                bitmap = {8'h08, 8'h18, 8'h28, 8'h08, 8'h08, 8'h08, 8'h3e, 8'h00};
            end
            TWO: begin
                bitmap = {8'h3c, 8'h42, 8'h02, 8'h0c, 8'h30, 8'h40, 8'h7e, 8'h00};
            end
            default: begin
                bitmap = '0;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // registered read
    ////////////////////////////////////////////////////////////////////////////

    // one cycle from addr to row
    always_ff @(posedge clk) begin
        row <= bitmap[cell_row];
    end

endmodule

/* source/font_ctrl.sv */
module font_ctrl
    import video_pkg::*;
    import font_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  beam_t  beam_in,
    input  logic   in_text,
    input  glyph_t glyph,
    // cell origin, half-resolution
    input  cnt_t   cell_h,
    input  cnt_t   cell_v,
    output beam_t  beam_out,
    output logic   text_px
);

    cnt_t       dx;
    cnt_t       dy;
    font_pos_t  col;
    font_pos_t  row_sel;
    font_pos_t  col_q;
    font_addr_t rom_addr;
    font_row_t  rom_row;
    beam_t      beam_q;
    logic       in_text_q;

    ////////////////////////////////////////////////////////////////////////////
    // position inside the cell
    ////////////////////////////////////////////////////////////////////////////

    // halved beam minus cell origin
    assign dx = (beam_in.h_cnt >> 1) - cell_h;
    assign dy = (beam_in.v_cnt >> 1) - cell_v;

    // low bits are enough, the cell is 8x8
    assign col     = dx[FONT_POS_W-1:0];
    assign row_sel = dy[FONT_POS_W-1:0];

    // glyph selects the bitmap, row selects the line
    assign rom_addr = {glyph, row_sel};

    font_rom u_font_rom (
        .clk  (clk),
        .addr (rom_addr),
        .row  (rom_row)
    );

    ////////////////////////////////////////////////////////////////////////////
    // alignment with the rom read
    ////////////////////////////////////////////////////////////////////////////

    // beam and flag ride along with the one-cycle read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beam_q    <= '0;
            in_text_q <= 1'b0;
        end else begin
            beam_q    <= beam_in;
            in_text_q <= in_text;
        end
    end

    // column only steers the bit select
    always_ff @(posedge clk) begin
        col_q <= col;
    end

    // bit 7 is column 0
    assign text_px = in_text_q
                   & rom_row[font_pos_t'(FONT_W - 1) - col_q]
                   & beam_q.active;

    assign beam_out = beam_q;

endmodule

/* source/text_overlay_top.sv */
module text_overlay_top
    import video_pkg::*;
    import font_pkg::*;
#(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33,
    parameter int STR_LEN  = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  cnt_t                 text_h,
    input  cnt_t                 text_v,
    input  glyph_t [STR_LEN-1:0] text_str,
    input  rgb_t                 fg_color,
    input  rgb_t                 bg_color,
    output video_t               video
);

    // beam at each pipeline stage
    beam_t  beam_scan;
    beam_t  beam_text;
    beam_t  beam_font;
    logic   in_text;
    glyph_t glyph;
    cnt_t   cell_h;
    cnt_t   cell_v;
    logic   text_px;
    rgb_t   rgb_next;

    video_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK)
    ) u_video_timing (
        .clk  (clk),
        .rst_n(rst_n),
        .beam (beam_scan)
    );

    // stage 1, glyph and cell origin
    text_ctrl #(
        .STR_LEN (STR_LEN)
    ) u_text_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .beam_in  (beam_scan),
        .text_h   (text_h),
        .text_v   (text_v),
        .text_str (text_str),
        .beam_out (beam_text),
        .in_text  (in_text),
        .glyph    (glyph),
        .cell_h   (cell_h),
        .cell_v   (cell_v)
    );

    // stage 2, rom read and pixel bit
    font_ctrl u_font_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .beam_in  (beam_text),
        .in_text  (in_text),
        .glyph    (glyph),
        .cell_h   (cell_h),
        .cell_v   (cell_v),
        .beam_out (beam_font),
        .text_px  (text_px)
    );

    ////////////////////////////////////////////////////////////////////////////
    // output word
    ////////////////////////////////////////////////////////////////////////////

    // fg on text, bg elsewhere in the picture, black in blanking
    always_comb begin
        if (text_px) begin
            rgb_next = fg_color;
        end else if (beam_font.active) begin
            rgb_next = bg_color;
        end else begin
            rgb_next = '0;
        end
    end

    // stage 3, sync and de stay aligned with the pixel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            video <= '0;
        end else begin
            video.hsync   <= beam_font.hsync;
            video.vsync   <= beam_font.vsync;
            video.de      <= beam_font.active;
            video.text_on <= text_px;
            video.rgb     <= rgb_next;
        end
    end

endmodule

/* bench/tb_text_model.svh */
`ifndef TB_TEXT_MODEL_SVH
`define TB_TEXT_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// reference font
////////////////////////////////////////////////////////////////////////////

// one glyph as 64 bits, top row in the upper byte
function automatic font_row_t glyph_row(glyph_t code, int row);
    logic [63:0] bits;
    case (glyph_code_e'(code))
        A:       bits = 64'h1824_4242_7e42_4200;
        B:       bits = 64'h7c42_427c_4242_7c00;
        C:       bits = 64'h3c42_4040_4042_3c00;
        D:       bits = 64'h7844_4242_4244_7800;
        ZERO:    bits = 64'h3c46_4a52_6242_3c00;
        ONE:     bits = 64'h0818_2808_0808_3e00;
        TWO:     bits = 64'h3c42_020c_3040_7e00;
        default: bits = 64'h0;
    endcase
    return bits[63 - 8 * row -: 8];
endfunction

// lit pixel at full-resolution (h,v), string scaled by two
function automatic logic expected_px(cnt_t h, cnt_t v, cnt_t th, cnt_t tv,
                                     glyph_t [STR_LEN-1:0] str);
    int        dx;
    int        dy;
    font_row_t bits;
    dx = int'(h) / 2 - int'(th);
    dy = int'(v) / 2 - int'(tv);
    // nothing lit in blanking
    if (h >= H_ACTIVE || v >= V_ACTIVE)
        return 1'b0;
    if (dx < 0 || dx >= FONT_W * STR_LEN || dy < 0 || dy >= FONT_H)
        return 1'b0;
    bits = glyph_row(str[dx / FONT_W], dy);
    // msb is the left column
    return bits[FONT_W - 1 - dx % FONT_W];
endfunction

////////////////////////////////////////////////////////////////////////////
// compare tasks
////////////////////////////////////////////////////////////////////////////

task automatic check_video(string name, video_t exp, video_t act);
    if (act !== exp) begin
        $display("ERR %s expected %h actual %h", name, exp, act);
        $display("=== FAIL ===");
        $fatal(1);
    end
endtask

task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp) begin
        $display("ERR %s expected %b actual %b", name, exp, act);
        $display("=== FAIL ===");
        $fatal(1);
    end
endtask

`endif

/* bench/tb_text_overlay.sv */
module tb_text_overlay
    import video_pkg::*;
    import font_pkg::*;
();

    // small raster of 76 x 30 totals
    localparam int H_ACTIVE = 64;
    localparam int H_FRONT  = 4;
    localparam int H_SYNC   = 4;
    localparam int H_BACK   = 4;
    localparam int V_ACTIVE = 24;
    localparam int V_FRONT  = 2;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 2;
    localparam int STR_LEN  = 4;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int FRAME    = H_TOTAL * V_TOTAL;
    localparam int PERIOD   = 8;
    localparam int SEED     = 99034;
    // each test takes at most two frames
    localparam int N_TESTS  = 6;
    localparam int LIMIT    = N_TESTS * 2 * FRAME + 200;

    // tracked beam position for one pipeline stage
    typedef struct packed {
        logic valid;
        cnt_t h;
        cnt_t v;
    } pos_t;

    logic                 clk;
    logic                 rst_n;
    cnt_t                 text_h;
    cnt_t                 text_v;
    glyph_t [STR_LEN-1:0] text_str;
    rgb_t                 fg_color;
    rgb_t                 bg_color;
    video_t               video;

    cnt_t beam_h;
    cnt_t beam_v;
    // entry 2 matches the current output word
    pos_t pipe [0:2];

    `include "tb_text_model.svh"

    text_overlay_top #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK),
        .STR_LEN  (STR_LEN)
    ) UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .text_h   (text_h),
        .text_v   (text_v),
        .text_str (text_str),
        .fg_color (fg_color),
        .bg_color (bg_color),
        .video    (video)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(LIMIT * PERIOD);
        $display("watchdog: tests did not finish within %0d cycles, run hung", LIMIT);
        $display("=== FAIL ===");
        $fatal(1);
    end

    ////////////////////////////////////////////////////////////////////////////
    // position tracking over the 3-cycle latency
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beam_h  <= '0;
            beam_v  <= '0;
            pipe[0] <= '0;
            pipe[1] <= '0;
            pipe[2] <= '0;
        end else begin
            pipe[0] <= {1'b1, beam_h, beam_v};
            pipe[1] <= pipe[0];
            pipe[2] <= pipe[1];
            if (beam_h == H_TOTAL - 1) begin
                beam_h <= '0;
                beam_v <= (beam_v == V_TOTAL - 1) ? '0 : beam_v + 1'b1;
            end else begin
                beam_h <= beam_h + 1'b1;
            end
        end
    end

    function automatic video_t expected_video(pos_t p);
        video_t w;
        logic   act;
        act       = (p.h < H_ACTIVE) && (p.v < V_ACTIVE);
        w.hsync   = (p.h >= H_ACTIVE + H_FRONT) && (p.h < H_ACTIVE + H_FRONT + H_SYNC);
        w.vsync   = (p.v >= V_ACTIVE + V_FRONT) && (p.v < V_ACTIVE + V_FRONT + V_SYNC);
        w.de      = act;
        w.text_on = expected_px(p.h, p.v, text_h, text_v, text_str);
        w.rgb     = w.text_on ? fg_color : (act ? bg_color : rgb_t'(0));
        return w;
    endfunction

    // returns when the output word sits on the first blanking line
    // inputs may change from there on
    task automatic sync_to_blank();
        int n;
        n = 0;
        @(negedge clk);
        while (!(pipe[2].valid && pipe[2].h == 0 && pipe[2].v == V_ACTIVE)) begin
            if (n == FRAME) begin
                $display("output never reached the start of vertical blanking");
                $display("=== FAIL ===");
                $fatal(1);
            end
            @(negedge clk);
            n++;
        end
    endtask

    // checks one full frame word by word
    task automatic run_frame(string name, bit clip);
        pos_t   p;
        video_t exp;
        string  tag;
        repeat (FRAME) begin
            @(negedge clk);
            p   = pipe[2];
            tag = $sformatf("%s (%0d,%0d)", name, p.h, p.v);
            exp = expected_video(p);
            // nothing may leak into blanking
            if (clip && !exp.de) begin
                check_bit(tag, 1'b0, video.text_on);
                check_bit(tag, 1'b1, video.rgb == '0);
            end
            check_video(tag, exp, video);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset();
        check_video("reset", '0, video);
        rst_n = 1'b1;
        for (int k = 1; k <= 3; k++) begin
            @(negedge clk);
            // de of (0,0) shows up on the third word
            check_bit("de_rise", k == 3, video.de);
            if (k < 3)
                check_video("reset_flush", '0, video);
        end
    endtask

    // sync and de with no text in view
    task automatic test_sync_de();
        sync_to_blank();
        run_frame("sync_de", 1'b0);
    endtask

    // "AB01" at (4,2)
    task automatic test_fixed();
        sync_to_blank();
        text_h   = cnt_t'(4);
        text_v   = cnt_t'(2);
        text_str = {glyph_t'(ONE), glyph_t'(ZERO), glyph_t'(B), glyph_t'(A)};
        run_frame("fixed", 1'b0);
    endtask

    task automatic test_random();
        sync_to_blank();
        for (int i = 0; i < STR_LEN; i++)
            text_str[i] = glyph_t'($urandom % FONT_GLYPHS);
        text_h = cnt_t'($urandom % (H_ACTIVE / 2));
        text_v = cnt_t'($urandom % (V_ACTIVE / 2));
        run_frame("random", 1'b0);
    endtask

    // runs off the right and bottom edges
    task automatic test_clip();
        sync_to_blank();
        text_h   = cnt_t'(28);
        text_v   = cnt_t'(10);
        text_str = {glyph_t'(TWO), glyph_t'(D), glyph_t'(C), glyph_t'(A)};
        run_frame("clip", 1'b1);
    endtask

    // new colours from the next frame on
    task automatic test_colour();
        sync_to_blank();
        fg_color = 12'h0f0;
        bg_color = 12'h400;
        run_frame("colour", 1'b1);
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n    = 1'b0;
        // string parked outside the raster
        text_h   = cnt_t'(100);
        text_v   = cnt_t'(100);
        text_str = '0;
        fg_color = 12'hfff;
        bg_color = 12'h008;
        repeat (5) @(negedge clk);
        test_reset();
        test_sync_de();
        test_fixed();
        test_random();
        test_clip();
        test_colour();
        $display("=== PASS ===");
        $finish;
    end

endmodule

/* list.f */
+incdir+bench
source/video_pkg.sv
source/font_pkg.sv
source/video_timing.sv
source/text_ctrl.sv
source/font_rom.sv
source/font_ctrl.sv
source/text_overlay_top.sv
bench/tb_text_overlay.sv
